/* design/btLink_macros.svh */
`ifndef BT_LINK_MACROS_SVH
`define BT_LINK_MACROS_SVH

// ----------------------------------------
// Serial link timing
// ----------------------------------------

// Clock cycles per UART bit, kept small so simulation stays short.
`define BT_CLOCKS_PER_BIT 16

// ----------------------------------------
// Buffers and break
// ----------------------------------------

`define BT_BUFFER_DEPTH 8 // Entries per FIFO, a power of two.
`define BT_BUFFER_LEVEL_BITS 4 // Wide enough to hold a full count.

`define BT_BREAK_CYCLES 64 // Cycles the BREAK pin stays high.

`endif

/* design/btLinkPkg.sv */
`include "btLink_macros.svh"

package btLinkPkg;

	// One byte on the serial link or the host port.
	typedef logic [7:0] btByte;

	typedef logic [`BT_BUFFER_LEVEL_BITS-1:0] bufferLevel; // FIFO fill count.

	// Host status word.
	// Bit 0 is the module state pin, bit 1 the break in progress.
	// Bits 2 to 4 are the sticky flags, dropped send, receive overflow
	// and framing error. Bits 11:8 and 15:12 carry the two fill levels.
	typedef logic [15:0] statusWord;

	// Controller states. BREAKING takes priority over the transmit states.
	typedef enum logic [1:0] {
		IDLE,
		LAUNCH,
		SENDING,
		BREAKING
	} linkState;

endpackage

/* design/uartReceiver.sv */
`include "btLink_macros.svh"

module uartReceiver (
	input logic clock,
	input logic reset,
	input logic fpgaRxd,
	output btLinkPkg::btByte rxData,
	output logic byteReady,
	output logic frameError
);
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxPhase;

	localparam logic [7:0] lastTick = 8'(`BT_CLOCKS_PER_BIT - 1);
	localparam logic [7:0] halfTick = 8'(`BT_CLOCKS_PER_BIT / 2 - 1);

	logic [1:0] syncStage;
	logic rxSync;
	rxPhase phase;
	logic [7:0] tickCount;
	logic [2:0] bitIndex;

	assign rxSync = syncStage[1]; // Line value after the synchronizer.

	always_ff @(posedge clock) begin
		if (reset) begin
			syncStage <= 2'b11; // An idle line reads high.
		end else begin
			syncStage <= {syncStage[0], fpgaRxd};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= RX_IDLE;
			tickCount <= '0;
			bitIndex <= '0;
			byteReady <= 1'b0;
			frameError <= 1'b0;
		end else begin
			byteReady <= 1'b0;
			frameError <= 1'b0;
			case (phase)
				RX_IDLE: begin
					tickCount <= '0;
					if (!rxSync) phase <= RX_START; // Possible start edge.
				end
				RX_START: begin
					if (tickCount == halfTick) begin
						tickCount <= '0;
						bitIndex <= '0;
						phase <= rxSync ? RX_IDLE : RX_DATA; // A high line here was a glitch.
					end else begin
						tickCount <= tickCount + 8'd1;
					end
				end
				RX_DATA: begin
					if (tickCount == lastTick) begin
						tickCount <= '0;
						bitIndex <= bitIndex + 3'd1;
						if (bitIndex == 3'd7) phase <= RX_STOP;
					end else begin
						tickCount <= tickCount + 8'd1;
					end
				end
				RX_STOP: begin
					if (tickCount == lastTick) begin
						byteReady <= rxSync; // Middle of the stop bit.
						frameError <= !rxSync;
						phase <= RX_IDLE;
					end else begin
						tickCount <= tickCount + 8'd1;
					end
				end
				default: phase <= RX_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first, so shift in from the top.
	always_ff @(posedge clock) begin
		if (phase == RX_DATA && tickCount == lastTick) rxData <= {rxSync, rxData[7:1]};
	end

	// A confirmed start bit leads to a stop bit result nine bit times later.
	assert property (@(posedge clock) disable iff (reset)
		$rose(phase == RX_DATA) |-> ##(9 * `BT_CLOCKS_PER_BIT) (byteReady || frameError));

endmodule

/* design/uartTransmitter.sv */
`include "btLink_macros.svh"

module uartTransmitter (
	input logic clock,
	input logic reset,
	input logic start,
	input btLinkPkg::btByte txData,
	output logic fpgaTxd,
	output logic busy
);
	localparam logic [7:0] lastTick = 8'(`BT_CLOCKS_PER_BIT - 1);

	logic [9:0] frame;
	logic [7:0] tickCount;
	logic [3:0] bitCount;

	// The line always shows the low end of the frame register.
	assign fpgaTxd = frame[0];

	always_ff @(posedge clock) begin
		if (reset) begin
			frame <= '1; // Idle line is high.
			tickCount <= '0;
			bitCount <= '0;
			busy <= 1'b0;
		end else if (!busy) begin
			if (start) begin
				frame <= {1'b1, txData, 1'b0}; // Stop, data LSB first, start.
				tickCount <= '0;
				bitCount <= '0;
				busy <= 1'b1;
			end
		end else begin
			if (tickCount == lastTick) begin
				tickCount <= '0;
				frame <= {1'b1, frame[9:1]}; // Ones refill the line behind the stop bit.
				bitCount <= bitCount + 4'd1;
				if (bitCount == 4'd9) busy <= 1'b0; // End of the stop bit.
			end else begin
				tickCount <= tickCount + 8'd1;
			end
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// The controller must wait for the frame to finish before the next start.
	assert property (@(posedge clock) disable iff (reset) !(start && busy));

endmodule

/* design/messageBuffer.sv */
`include "btLink_macros.svh"

module messageBuffer (
	input logic clock,
	input logic reset,
	input logic push,
	input btLinkPkg::btByte pushData,
	input logic pop,
	output btLinkPkg::btByte popData,
	output btLinkPkg::bufferLevel level
);
	import btLinkPkg::*;

	localparam int ptrBits = $clog2(`BT_BUFFER_DEPTH);
	localparam bufferLevel fullLevel = bufferLevel'(`BT_BUFFER_DEPTH);

	btByte storage [`BT_BUFFER_DEPTH];
	logic [ptrBits-1:0] writePtr;
	logic [ptrBits-1:0] readPtr;
	logic doPush;
	logic doPop;

	assign doPush = push && (level != fullLevel); // A push to a full buffer is dropped.
	assign doPop = pop && (level != '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr <= '0;
			readPtr <= '0;
			level <= '0;
		end else begin
			if (doPush) writePtr <= writePtr + 1'b1;
			if (doPop) readPtr <= readPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (doPush) storage[writePtr] <= pushData;
		if (doPop) popData <= storage[readPtr]; // Holds its value when nothing is popped.
	end

	assert property (@(posedge clock) disable iff (reset) level <= fullLevel);

endmodule

/* design/linkController.sv */
`include "btLink_macros.svh"

module linkController (
	input logic clock,
	input logic reset,
	input logic btState,
	input logic sendRequest,
	input logic breakRequest,
	input logic clearStatus,
	input btLinkPkg::bufferLevel txLevel,
	input btLinkPkg::bufferLevel rxLevel,
	input logic txBusy,
	input logic byteReady,
	input logic frameError,
	output logic txPush,
	output logic txPop,
	output logic txStart,
	output logic btBreak,
	output btLinkPkg::statusWord status
);
	import btLinkPkg::*;

	localparam int breakBits = $clog2(`BT_BREAK_CYCLES);
	localparam logic [breakBits-1:0] lastBreak = breakBits'(`BT_BREAK_CYCLES - 1);
	localparam bufferLevel fullLevel = bufferLevel'(`BT_BUFFER_DEPTH);

	linkState state;
	linkState nextState;
	logic [breakBits-1:0] breakCount;
	logic sendAccept;
	logic [2:0] stickyNext;

	assign btBreak = (state == BREAKING);

	// A send needs a connected module, room in the queue and no break.
	assign sendAccept = btState && (txLevel != fullLevel) && !btBreak;
	assign txPush = sendRequest && sendAccept;

	// ----------------------------------------
	// Transmit sequencing and break
	// ----------------------------------------

	always_comb begin
		nextState = state;
		txPop = 1'b0;
		txStart = 1'b0;
		case (state)
			IDLE: begin
				if (txLevel != '0) begin
					txPop = 1'b1;
					nextState = LAUNCH;
				end
			end
			LAUNCH: begin
				if (!txBusy) begin
					txStart = 1'b1; // popData of the buffer feeds the transmitter.
					nextState = SENDING;
				end
			end
			SENDING: begin
				// Fetch the next byte early so frames follow with a one cycle gap.
				if (txLevel != '0) begin
					txPop = 1'b1;
					nextState = LAUNCH;
				end else if (!txBusy) begin
					nextState = IDLE;
				end
			end
			BREAKING: begin
				if (breakCount == lastBreak) nextState = IDLE;
			end
			default: nextState = IDLE;
		endcase
		// A break drops the link, so a byte waiting for launch is discarded.
		if (breakRequest && state != BREAKING) begin
			nextState = BREAKING;
			txPop = 1'b0;
			txStart = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			breakCount <= '0;
		end else begin
			state <= nextState;
			if (state != BREAKING) breakCount <= '0;
			else breakCount <= breakCount + 1'b1;
		end
	end

	// ----------------------------------------
	// Status word
	// ----------------------------------------

	always_comb begin
		stickyNext = clearStatus ? 3'b000 : status[4:2];
		if (sendRequest && !sendAccept) stickyNext[0] = 1'b1; // Dropped send.
		if (byteReady && rxLevel == fullLevel) stickyNext[1] = 1'b1; // Receive overflow.
		if (frameError) stickyNext[2] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			status <= '0;
		end else begin
			status <= {rxLevel, txLevel, 3'b000, stickyNext, btBreak, btState};
		end
	end

	// The BREAK pin holds for the full length and then releases.
	assert property (@(posedge clock) disable iff (reset)
		$rose(btBreak) |-> ##(`BT_BREAK_CYCLES - 1) btBreak ##1 !btBreak);

endmodule

/* design/bluetoothConnection.sv */
module bluetoothConnection (
	input logic clock,
	input logic reset,
	input logic btState,
	input logic fpgaRxd,
	input logic sendRequest,
	input btLinkPkg::btByte hostByte,
	input logic readRequest,
	input logic breakRequest,
	input logic clearStatus,
	output logic fpgaTxd,
	output logic btBreak,
	output btLinkPkg::btByte rxByte,
	output btLinkPkg::statusWord status
);
	import btLinkPkg::*;

	logic txPush;
	logic txPop;
	logic txStart;
	logic txBusy;
	btByte txHeadByte;
	bufferLevel txLevel;
	btByte rxData;
	logic byteReady;
	logic frameError;
	bufferLevel rxLevel;

	// ----------------------------------------
	// Control
	// ----------------------------------------

	linkController controller (
		.clock(clock),
		.reset(reset),
		.btState(btState),
		.sendRequest(sendRequest),
		.breakRequest(breakRequest),
		.clearStatus(clearStatus),
		.txLevel(txLevel),
		.rxLevel(rxLevel),
		.txBusy(txBusy),
		.byteReady(byteReady),
		.frameError(frameError),
		.txPush(txPush),
		.txPop(txPop),
		.txStart(txStart),
		.btBreak(btBreak),
		.status(status)
	);

	// ----------------------------------------
	// Transmit path to the module's RXD
	// ----------------------------------------

	messageBuffer txBuffer (
		.clock(clock),
		.reset(reset),
		.push(txPush),
		.pushData(hostByte),
		.pop(txPop),
		.popData(txHeadByte),
		.level(txLevel)
	);

	uartTransmitter transmitter (
		.clock(clock),
		.reset(reset),
		.start(txStart),
		.txData(txHeadByte),
		.fpgaTxd(fpgaTxd),
		.busy(txBusy)
	);

	// Receive path, the host pops rxBuffer directly.
	uartReceiver receiver (
		.clock(clock),
		.reset(reset),
		.fpgaRxd(fpgaRxd),
		.rxData(rxData),
		.byteReady(byteReady),
		.frameError(frameError)
	);

	messageBuffer rxBuffer (
		.clock(clock),
		.reset(reset),
		.push(byteReady),
		.pushData(rxData),
		.pop(readRequest),
		.popData(rxByte),
		.level(rxLevel)
	);

endmodule

/* tb/bluetoothConnectionTb.sv */
`include "btLink_macros.svh"

module bluetoothConnectionTb;
	import btLinkPkg::*;

	localparam int bitCycles = `BT_CLOCKS_PER_BIT;
	localparam int frameCycles = 10 * `BT_CLOCKS_PER_BIT;

	logic clock = 1'b0;
	logic reset;
	logic btState;
	logic fpgaRxd;
	logic sendRequest;
	btByte hostByte;
	logic readRequest;
	logic breakRequest;
	logic clearStatus;
	logic fpgaTxd;
	logic btBreak;
	btByte rxByte;
	statusWord status;

	logic [63:0] opList[$];
	btByte dataList[$];
	logic [15:0] expectList[$];
	btByte expectedTx[$];
	btByte decodedTx[$];
	btByte expectedRx[$];
	int errorCount = 0;
	int checkCount = 0;
	int recordCount = 0;
	logic [31:0] lcgState = 32'hf1fd;
	btByte monitorByte;

	bluetoothConnection UUT (
		.clock(clock),
		.reset(reset),
		.btState(btState),
		.fpgaRxd(fpgaRxd),
		.sendRequest(sendRequest),
		.hostByte(hostByte),
		.readRequest(readRequest),
		.breakRequest(breakRequest),
		.clearStatus(clearStatus),
		.fpgaTxd(fpgaTxd),
		.btBreak(btBreak),
		.rxByte(rxByte),
		.status(status)
	);

	always #50 clock = ~clock;

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic waitStatus(); // Status trails the FIFO levels by a cycle.
		repeat (3) @(posedge clock);
		@(negedge clock);
	endtask

	task automatic sendByte(input btByte value);
		@(posedge clock);
		sendRequest <= 1'b1;
		hostByte <= value;
		@(posedge clock);
		sendRequest <= 1'b0;
	endtask

	task automatic readByte(output btByte value);
		@(posedge clock);
		readRequest <= 1'b1;
		@(posedge clock);
		readRequest <= 1'b0;
		@(negedge clock);
		value = rxByte; // Registered one cycle after the request.
	endtask

	task automatic clearFlags();
		@(posedge clock);
		clearStatus <= 1'b1;
		@(posedge clock);
		clearStatus <= 1'b0;
	endtask

	// HM-10 side of the link. A zero stop bit models a corrupted frame.
	task automatic injectFrame(input btByte value, input logic stopBit);
		@(posedge clock);
		fpgaRxd <= 1'b0;
		repeat (bitCycles) @(posedge clock);
		for (int i = 0; i < 8; i++) begin
			fpgaRxd <= value[i];
			repeat (bitCycles) @(posedge clock);
		end
		fpgaRxd <= stopBit;
		repeat (bitCycles) @(posedge clock);
		fpgaRxd <= 1'b1; // One idle bit before the next frame.
		repeat (bitCycles) @(posedge clock);
	endtask

	// Decodes fpgaTxd at mid-bit, sampled on the falling clock edge.
	always begin
		@(negedge clock);
		if (!reset && fpgaTxd === 1'b0) begin
			repeat (bitCycles / 2) @(negedge clock);
			check("fpgaTxd start bit", fpgaTxd, 0);
			for (int i = 0; i < 8; i++) begin
				repeat (bitCycles) @(negedge clock);
				monitorByte[i] = fpgaTxd;
			end
			repeat (bitCycles) @(negedge clock);
			check("fpgaTxd stop bit", fpgaTxd, 1);
			decodedTx.push_back(monitorByte);
		end
	end

	// ----------------------------------------
	// Tests
	// ----------------------------------------

	task automatic runTransmitDone(input int count);
		int waitCycles;
		waitCycles = 0;
		while (decodedTx.size() < count && waitCycles < count * 12 * bitCycles * 10) begin
			@(negedge clock);
			waitCycles++;
		end
		check("frames decoded", decodedTx.size(), count);
		while (decodedTx.size() > 0 && expectedTx.size() > 0)
			check("fpgaTxd byte", decodedTx.pop_front(), expectedTx.pop_front());
		waitStatus();
		check("txLevel", status[11:8], 0);
		decodedTx.delete();
		expectedTx.delete();
	endtask

	task automatic runReceiveDone(input int count);
		int remaining;
		btByte value;
		remaining = count;
		while (expectedRx.size() > 0) begin
			waitStatus();
			check("rxLevel", status[15:12], remaining);
			readByte(value);
			check("rxByte", value, expectedRx.pop_front());
			remaining--;
		end
		waitStatus();
		check("rxLevel", status[15:12], 0);
	endtask

	// A refused byte must never reach the line, even after a break ends.
	task automatic checkDropped(input logic [15:0] expected);
		repeat (`BT_BREAK_CYCLES + frameCycles + 2 * bitCycles) @(negedge clock);
		check("frames decoded", decodedTx.size(), 0);
		check("sticky flags", status & 16'h001c, expected);
		clearFlags();
		waitStatus();
		check("sticky flags after clear", status & 16'h001c, 0);
	endtask

	task automatic runOverflow(input logic [15:0] expected);
		btByte sent[$];
		btByte value;
		for (int k = 0; k <= `BT_BUFFER_DEPTH; k++) begin
			lcgState = lcgNext(lcgState);
			if (k < `BT_BUFFER_DEPTH) sent.push_back(lcgState[23:16]); // The last one is lost.
			injectFrame(lcgState[23:16], 1'b1);
		end
		waitStatus();
		check("sticky flags", status & 16'h001c, expected);
		check("rxLevel", status[15:12], `BT_BUFFER_DEPTH);
		while (sent.size() > 0) begin
			readByte(value);
			check("rxByte", value, sent.pop_front());
		end
		waitStatus();
		check("rxLevel", status[15:12], 0);
		clearFlags();
	endtask

	task automatic runFraming(input btByte value, input logic [15:0] expected);
		injectFrame(value, 1'b0);
		waitStatus();
		check("sticky flags", status & 16'h001c, expected);
		check("rxLevel", status[15:12], expectedRx.size()); // Bytes injected and not yet read.
		clearFlags();
	endtask

	task automatic runBreak(input logic [15:0] expected);
		int highCycles;
		@(posedge clock);
		breakRequest <= 1'b1;
		@(negedge clock);
		check("btBreak before request edge", btBreak, 0);
		@(posedge clock);
		breakRequest <= 1'b0;
		@(negedge clock);
		check("btBreak one cycle after request", btBreak, 1);
		highCycles = 0;
		while (btBreak === 1'b1 && highCycles < 4 * `BT_BREAK_CYCLES) begin
			highCycles++;
			@(negedge clock);
		end
		check("btBreak high cycles", highCycles, expected);
		check("status break bit", status[1], 1); // Status still shows the last break cycle.
		@(negedge clock);
		check("status break bit after release", status[1], 0);
	endtask

	// Allows 12 frame times per record plus the reset.
	initial begin
		wait (recordCount > 0);
		#((recordCount * 12 * frameCycles + 10) * 100);
		$display("Timeout: the tests did not finish in the time allowed.");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int fd;
		string line;
		logic [63:0] opName;
		btByte dataVal;
		logic [15:0] expectVal;
		int errorsBefore;
		reset = 1'b1;
		btState = 1'b1;
		fpgaRxd = 1'b1;
		sendRequest = 1'b0;
		hostByte = '0;
		readRequest = 1'b0;
		breakRequest = 1'b0;
		clearStatus = 1'b0;
		fd = $fopen("tb/bluetoothConnection_golden.txt", "r");
		if (fd == 0) begin
			errorCount++;
			$display("Could not open the golden file.");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					if ($sscanf(line, "%s %h %h", opName, dataVal, expectVal) == 3) begin
						opList.push_back(opName);
						dataList.push_back(dataVal);
						expectList.push_back(expectVal);
					end
				end
			end
			$fclose(fd);
		end
		recordCount = opList.size();
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		repeat (2) @(posedge clock);
		for (int n = 0; n < recordCount; n++) begin
			errorsBefore = errorCount;
			case (opList[n])
				"TX": begin
					expectedTx.push_back(btByte'(expectList[n]));
					sendByte(dataList[n]);
				end
				"TXDONE": runTransmitDone(expectList[n]);
				"RX": begin
					expectedRx.push_back(btByte'(expectList[n]));
					injectFrame(dataList[n], 1'b1);
				end
				"RXDONE": runReceiveDone(expectList[n]);
				"DROP": begin
					@(posedge clock);
					btState <= 1'b0; // Module not connected.
					sendByte(dataList[n]);
					checkDropped(expectList[n]);
					check("btState in status", status[0], 0);
					@(posedge clock);
					btState <= 1'b1;
				end
				"BRKDROP": begin
					@(posedge clock);
					breakRequest <= 1'b1;
					@(posedge clock);
					breakRequest <= 1'b0;
					sendByte(dataList[n]);
					checkDropped(expectList[n]);
				end
				"OVER": runOverflow(expectList[n]);
				"FRAME": runFraming(dataList[n], expectList[n]);
				"BREAK": runBreak(expectList[n]);
				default: begin
					errorCount++;
					$display("Unknown operation in record %0d of the golden file.", n);
				end
			endcase
			$display("test %0d %0s: %s", n, opList[n], (errorCount == errorsBefore) ? "ok" : "failed");
		end
		$display("tests %0d, checks %0d, errors %0d", recordCount, checkCount, errorCount);
		if (errorCount == 0) $display("** PASS **");
		else $display("** FAIL **");
		$finish;
	end

endmodule

/* tb/bluetoothConnection_golden.txt */
# Columns: operation, data byte (hex), expected value (hex).
# TX and RX queue a byte, TXDONE and RXDONE expect a count, BREAK expects high cycles, others expect status bits 4:2.
TX 55 55
TX a3 a3
TX 0f 0f
TXDONE 00 03
RX 3c 3c
RX c9 c9
RXDONE 00 02
DROP 77 04
BRKDROP 66 04
OVER 00 08
FRAME 5a 10
BREAK 00 40

/* all.f */
+incdir+design
design/btLinkPkg.sv
design/uartReceiver.sv
design/uartTransmitter.sv
design/messageBuffer.sv
design/linkController.sv
design/bluetoothConnection.sv
tb/bluetoothConnectionTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module bluetoothConnectionTb \
	-f all.f -o btLinkSim

./obj_dir/btLinkSim | tee sim.log

if grep -qF "** FAIL **" sim.log; then
	echo "Simulation reported a failure."
	exit 1
fi
echo "Simulation finished without failures."
